//--- common/gcn_pkg.sv
package gcn_pkg;

    ////////////////////
    // sizes
    ////////////////////
    localparam int NUM_NODES   = 6;
    localparam int NUM_EDGES   = 6;   // edge slots in coo list
    localparam int NUM_FEATS   = 8;   // feature columns == weight rows
    localparam int NUM_CLASSES = 3;

    localparam int DATA_W    = 5;     // unsigned feature / weight element
    localparam int AGG_W     = 8;     // 6 * 31 fits
    localparam int ACC_W     = 16;    // 8 * 186 * 31 fits
    localparam int NODE_ID_W = 3;     // id 0 means no edge
    localparam int ADDR_W    = 3;
    localparam int CLASS_W   = 2;

    ////////////////////
    // data types
    ////////////////////
    typedef logic [NODE_ID_W-1:0] node_id_t;

    // used for both source and destination lists
    typedef node_id_t [NUM_EDGES-1:0] edge_list_t;

    typedef logic [NUM_NODES-1:0][DATA_W-1:0]   feat_col_t;   // one column, one element per node
    typedef logic [NUM_CLASSES-1:0][DATA_W-1:0] weight_row_t;

    // row i holds the neighbours of node i
    typedef logic [NUM_NODES-1:0][NUM_NODES-1:0] adj_mat_t;

    typedef logic [NUM_NODES-1:0][AGG_W-1:0]   agg_vec_t;
    typedef logic [NUM_NODES-1:0][CLASS_W-1:0] class_vec_t;

    // run sequence of the controller
    typedef enum logic [2:0] {
        IDLE,
        LOAD,     // sample edge lists
        ADJ,      // one edge per cycle
        STREAM,   // memory reads
        DRAIN,    // wait for the class choice
        FINISH
    } ctrl_state_e;

endpackage

//--- common/feat_stream_if.sv
// aggregated node vectors plus the matching weight row
interface feat_stream_if;

    logic                 valid;   // no ready, every beat is taken
    logic                 last;    // beat of the final feature column
    gcn_pkg::agg_vec_t    agg;
    gcn_pkg::weight_row_t weight;

    modport src (
        output valid,
        output last,
        output agg,
        output weight
    );

    modport dst (
        input valid,
        input last,
        input agg,
        input weight
    );

endinterface

//--- gcn/gcn_ctrl.sv
module gcn_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic                       adj_done,
    input  logic                       result_valid,
    output logic                       load,
    output logic                       adj_en,
    output logic                       mem_re,
    output logic [gcn_pkg::ADDR_W-1:0] mem_addr,
    output logic                       done
);

    gcn_pkg::ctrl_state_e       state;
    gcn_pkg::ctrl_state_e       state_nxt;
    logic [gcn_pkg::ADDR_W-1:0] addr;      // feature column k and weight row k
    logic                       addr_last;

    assign addr_last = (addr == gcn_pkg::ADDR_W'(gcn_pkg::NUM_FEATS - 1));

    ////////////////////
    // state register
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= gcn_pkg::IDLE;
            addr  <= '0;
        end else begin
            state <= state_nxt;
            if (state == gcn_pkg::STREAM) begin
                addr <= addr_last ? '0 : addr + 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            gcn_pkg::IDLE:   if (start) state_nxt = gcn_pkg::LOAD;
            gcn_pkg::LOAD:   state_nxt = gcn_pkg::ADJ;
            gcn_pkg::ADJ:    if (adj_done) state_nxt = gcn_pkg::STREAM;   // last edge this cycle
            gcn_pkg::STREAM: if (addr_last) state_nxt = gcn_pkg::DRAIN;
            gcn_pkg::DRAIN:  if (result_valid) state_nxt = gcn_pkg::FINISH;
            gcn_pkg::FINISH: state_nxt = gcn_pkg::IDLE;
            default:         state_nxt = gcn_pkg::IDLE;
        endcase
    end

    ////////////////////
    // outputs
    ////////////////////
    assign load     = (state == gcn_pkg::LOAD);
    assign adj_en   = (state == gcn_pkg::ADJ);
    assign mem_re   = (state == gcn_pkg::STREAM);
    assign mem_addr = addr;
    assign done     = (state == gcn_pkg::FINISH);   // single cycle, back to idle after

    // address rests at column 0 between read bursts
    a_re_in_stream: assert property (
        @(posedge clk) disable iff (!rst_n)
        !mem_re |-> mem_addr == '0
    );

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    );

endmodule

//--- gcn/adj_builder.sv
module adj_builder (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load,
    input  logic                adj_en,
    input  gcn_pkg::edge_list_t edge_src,
    input  gcn_pkg::edge_list_t edge_dst,
    output logic                adj_done,
    output gcn_pkg::adj_mat_t   adj_mat
);

    gcn_pkg::edge_list_t                      src_q;
    gcn_pkg::edge_list_t                      dst_q;
    logic [$clog2(gcn_pkg::NUM_EDGES)-1:0]    edge_idx;
    gcn_pkg::node_id_t                        cur_src;
    gcn_pkg::node_id_t                        cur_dst;
    logic                                     edge_ok;

    assign cur_src = src_q[edge_idx];
    assign cur_dst = dst_q[edge_idx];

    // zero id, id past the last node and self loops are dropped
    assign edge_ok = (cur_src != '0) && (cur_src <= gcn_pkg::NUM_NODES) &&
                     (cur_dst != '0) && (cur_dst <= gcn_pkg::NUM_NODES) &&
                     (cur_src != cur_dst);

    assign adj_done = adj_en && (edge_idx == gcn_pkg::NUM_EDGES - 1);

    always_ff @(posedge clk) begin
        if (load) begin
            src_q <= edge_src;
            dst_q <= edge_dst;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adj_mat  <= '0;
            edge_idx <= '0;
        end else if (load) begin
            adj_mat  <= '0;
            edge_idx <= '0;
        end else if (adj_en) begin
            edge_idx <= edge_idx + 1'b1;
            if (edge_ok) begin
                adj_mat[cur_src - 1'b1][cur_dst - 1'b1] <= 1'b1;   // duplicates just set again
                adj_mat[cur_dst - 1'b1][cur_src - 1'b1] <= 1'b1;
            end
        end
    end

    for (genvar i = 0; i < gcn_pkg::NUM_NODES; i++) begin : g_sym_row
        for (genvar j = i + 1; j < gcn_pkg::NUM_NODES; j++) begin : g_sym_col
            a_symmetric: assert property (
                @(posedge clk) disable iff (!rst_n)
                adj_mat[i][j] == adj_mat[j][i]
            );
        end
    end

endmodule

//--- gcn/feat_aggregator.sv
module feat_aggregator (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       mem_re,
    input  logic [gcn_pkg::ADDR_W-1:0] mem_addr,
    input  gcn_pkg::feat_col_t         feat_data,
    input  gcn_pkg::weight_row_t       weight_data,
    input  gcn_pkg::adj_mat_t          adj_mat,
    feat_stream_if.src                 stream
);

    logic               data_valid;   // memory data present this cycle
    logic               data_last;
    gcn_pkg::agg_vec_t  sum;

    ////////////////////
    // request -> data
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_valid <= 1'b0;
            data_last  <= 1'b0;
        end else begin
            data_valid <= mem_re;
            data_last  <= mem_re && (mem_addr == gcn_pkg::ADDR_W'(gcn_pkg::NUM_FEATS - 1));
        end
    end

    // neighbour sum of the current column, per node
    always_comb begin
        for (int i = 0; i < gcn_pkg::NUM_NODES; i++) begin
            sum[i] = '0;
            for (int j = 0; j < gcn_pkg::NUM_NODES; j++) begin
                if (adj_mat[i][j]) sum[i] = sum[i] + gcn_pkg::AGG_W'(feat_data[j]);
            end
        end
    end

    ////////////////////
    // output beat
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stream.valid <= 1'b0;
            stream.last  <= 1'b0;
        end else begin
            stream.valid <= data_valid;
            stream.last  <= data_last;
        end
    end

    always_ff @(posedge clk) begin
        if (data_valid) begin
            stream.agg    <= sum;
            stream.weight <= weight_data;   // weight row k stays with column k
        end
    end

endmodule

//--- gcn/feat_transform.sv
module feat_transform (
    input  logic                clk,
    input  logic                rst_n,
    feat_stream_if.dst          stream,
    output logic                result_valid,
    output gcn_pkg::class_vec_t y
);

    logic [gcn_pkg::NUM_NODES-1:0][gcn_pkg::NUM_CLASSES-1:0][gcn_pkg::ACC_W-1:0] scores;
    logic                last_d;     // scores are final in this cycle
    gcn_pkg::class_vec_t best_idx;

    ////////////////////
    // multiply-accumulate
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scores <= '0;
            last_d <= 1'b0;
        end else begin
            last_d <= stream.valid && stream.last;
            if (last_d) begin
                scores <= '0;   // ready for the next run
            end else if (stream.valid) begin
                for (int n = 0; n < gcn_pkg::NUM_NODES; n++) begin
                    for (int c = 0; c < gcn_pkg::NUM_CLASSES; c++) begin
                        scores[n][c] <= scores[n][c] + stream.agg[n] * stream.weight[c];
                    end
                end
            end
        end
    end

    // argmax per node, strict compare keeps the lower index on a tie
    always_comb begin : pick_class
        logic [gcn_pkg::ACC_W-1:0] best_score;
        for (int n = 0; n < gcn_pkg::NUM_NODES; n++) begin
            best_score  = scores[n][0];
            best_idx[n] = '0;
            for (int c = 1; c < gcn_pkg::NUM_CLASSES; c++) begin
                if (scores[n][c] > best_score) begin
                    best_score  = scores[n][c];
                    best_idx[n] = gcn_pkg::CLASS_W'(c);
                end
            end
        end
    end

    ////////////////////
    // result
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y            <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= last_d;
            if (last_d) y <= best_idx;   // held until the next run
        end
    end

    // scores are cleared in the cycle after last, no beat may land there
    a_gap_after_last: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stream.valid && stream.last) |=> !stream.valid [*2]
    );

endmodule

//--- gcn/gcn_top.sv
module gcn_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  gcn_pkg::edge_list_t           edge_src,
    input  gcn_pkg::edge_list_t           edge_dst,
    input  gcn_pkg::feat_col_t            feat_data,
    input  gcn_pkg::weight_row_t          weight_data,
    output logic                          mem_re,
    output logic [gcn_pkg::ADDR_W-1:0]    mem_addr,
    output gcn_pkg::class_vec_t           y,
    output logic                          done
);

    logic              load;
    logic              adj_en;
    logic              adj_done;
    logic              result_valid;
    gcn_pkg::adj_mat_t adj_mat;

    feat_stream_if stream_if ();   // aggregator -> transform

    gcn_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .adj_done     (adj_done),
        .result_valid (result_valid),
        .load         (load),
        .adj_en       (adj_en),
        .mem_re       (mem_re),
        .mem_addr     (mem_addr),
        .done         (done)
    );

    adj_builder u_adj (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .adj_en   (adj_en),
        .edge_src (edge_src),
        .edge_dst (edge_dst),
        .adj_done (adj_done),
        .adj_mat  (adj_mat)
    );

    feat_aggregator u_agg (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_re      (mem_re),
        .mem_addr    (mem_addr),
        .feat_data   (feat_data),
        .weight_data (weight_data),
        .adj_mat     (adj_mat),
        .stream      (stream_if)
    );

    feat_transform u_xform (
        .clk          (clk),
        .rst_n        (rst_n),
        .stream       (stream_if),
        .result_valid (result_valid),
        .y            (y)
    );

endmodule

//--- dv/gcn_checker.sv
module gcn_checker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic                       mem_re,
    input  logic [gcn_pkg::ADDR_W-1:0] mem_addr,
    input  gcn_pkg::class_vec_t        y,
    input  logic                       done,
    input  gcn_pkg::class_vec_t        exp_y,
    output int                         mismatch_count,
    output int                         fault_count,
    output int                         done_count
);

    logic                started;
    logic                re_q;
    logic                done_q;
    logic                burst_seen;   // full read burst since the last done
    logic                y_moved;
    int                  read_idx;
    gcn_pkg::class_vec_t y_q;

    always @(posedge clk) begin
        if (!rst_n) begin
            started        = 1'b0;
            re_q           = 1'b0;
            done_q         = 1'b0;
            burst_seen     = 1'b0;
            y_moved        = 1'b0;
            read_idx       = 0;
            y_q            = '0;
            mismatch_count = 0;
            fault_count    = 0;
            done_count     = 0;
        end else begin
            if (!started && (done || mem_re || y != '0)) begin
                $display("Error at %0t: outputs not idle after reset", $time);
                fault_count++;
            end
            if (start) started = 1'b1;

            ////////////////////
            // read burst
            ////////////////////
            if (mem_re) begin
                if (burst_seen) begin
                    $display("Error at %0t: extra read after this run's burst", $time);
                    fault_count++;
                end
                if (mem_addr != gcn_pkg::ADDR_W'(read_idx)) begin
                    $display("Mismatch at %0t: mem_addr = %0d, expected %0d",
                             $time, mem_addr, read_idx);
                    mismatch_count++;
                end
                read_idx++;
            end else if (re_q) begin
                if (read_idx != gcn_pkg::NUM_FEATS) begin
                    $display("Error at %0t: read burst lasted %0d cycles", $time, read_idx);
                    fault_count++;
                end
                burst_seen = 1'b1;
                read_idx   = 0;
            end

            ////////////////////
            // done and result
            ////////////////////
            if (done && done_q) begin
                $display("Error at %0t: done stayed high for a second cycle", $time);
                fault_count++;
            end
            if (done && !done_q) begin
                done_count++;
                if (!burst_seen) begin
                    $display("Error at %0t: done without a read burst", $time);
                    fault_count++;
                end
                if (y != exp_y) begin
                    $display("Mismatch at %0t: y = %h, expected %h", $time, y, exp_y);
                    mismatch_count++;
                end
                burst_seen = 1'b0;
            end
            if (y_moved && !done) begin   // y updates one cycle ahead of done
                $display("Error at %0t: y changed without a done pulse", $time);
                fault_count++;
            end
            y_moved = (y != y_q);
            y_q     = y;
            re_q    = mem_re;
            done_q  = done;
        end
    end

endmodule

//--- dv/gcn_tb.sv
module gcn_tb;

    localparam int NUM_CASES       = 6;
    localparam int CASE_WORDS      = 19;   // src, dst, 8 columns, 8 weight rows, classes
    localparam int WATCHDOG_CYCLES = (NUM_CASES + 1) * 40;

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    gcn_pkg::edge_list_t        edge_src;
    gcn_pkg::edge_list_t        edge_dst;
    gcn_pkg::feat_col_t         feat_data;
    gcn_pkg::weight_row_t       weight_data;
    logic                       mem_re;
    logic [gcn_pkg::ADDR_W-1:0] mem_addr;
    gcn_pkg::class_vec_t        y;
    logic                       done;

    gcn_pkg::class_vec_t        exp_y;
    int                         mismatch_count;
    int                         fault_count;
    int                         done_count;
    int                         run_errors;
    int                         seed;

    logic [23:0]          golden_mem [0:NUM_CASES*CASE_WORDS-1];
    gcn_pkg::feat_col_t   cur_cols [0:gcn_pkg::NUM_FEATS-1];   // memory contents of one case
    gcn_pkg::weight_row_t cur_rows [0:gcn_pkg::NUM_FEATS-1];

    gcn_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .edge_src    (edge_src),
        .edge_dst    (edge_dst),
        .feat_data   (feat_data),
        .weight_data (weight_data),
        .mem_re      (mem_re),
        .mem_addr    (mem_addr),
        .y           (y),
        .done        (done)
    );

    gcn_checker u_chk (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .mem_re         (mem_re),
        .mem_addr       (mem_addr),
        .y              (y),
        .done           (done),
        .exp_y          (exp_y),
        .mismatch_count (mismatch_count),
        .fault_count    (fault_count),
        .done_count     (done_count)
    );

    // leftmost digit of a word is index 0
    function automatic logic [3:0] hex_digit(input logic [23:0] word, input int pos,
                                             input int len);
        return word[4*(len-1-pos) +: 4];
    endfunction

    task automatic load_case(input int idx);
        int base;
        base = idx * CASE_WORDS;
        for (int e = 0; e < gcn_pkg::NUM_EDGES; e++) begin
            edge_src[e] = gcn_pkg::NODE_ID_W'(hex_digit(golden_mem[base], e, 6));
            edge_dst[e] = gcn_pkg::NODE_ID_W'(hex_digit(golden_mem[base + 1], e, 6));
        end
        for (int k = 0; k < gcn_pkg::NUM_FEATS; k++) begin
            for (int n = 0; n < gcn_pkg::NUM_NODES; n++) begin
                cur_cols[k][n] = gcn_pkg::DATA_W'(hex_digit(golden_mem[base + 2 + k], n, 6));
            end
            for (int c = 0; c < gcn_pkg::NUM_CLASSES; c++) begin
                cur_rows[k][c] = gcn_pkg::DATA_W'(hex_digit(golden_mem[base + 10 + k], c, 3));
            end
        end
        for (int n = 0; n < gcn_pkg::NUM_NODES; n++) begin
            exp_y[n] = gcn_pkg::CLASS_W'(hex_digit(golden_mem[base + 18], n, 6));
        end
    endtask

    task automatic wait_for_done;
        @(posedge clk);
        while (!done) @(posedge clk);
    endtask

    task automatic report_counts(input int extra);
        $display("error counts: %0d mismatch, %0d protocol, %0d run",
                 mismatch_count, fault_count, extra);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // memory model
    ////////////////////
    initial begin : memory_model
        logic [gcn_pkg::ADDR_W-1:0] rd_addr;
        feat_data   = '0;
        weight_data = '0;
        forever begin
            @(posedge clk);
            if (mem_re) begin
                rd_addr = mem_addr;
                #1;
                feat_data   = cur_cols[rd_addr];   // valid through the next edge
                weight_data = cur_rows[rd_addr];
            end
        end
    end

    ////////////////////
    // stimulus
    ////////////////////
    initial begin : stimulus
        int idle;
        seed       = 91;
        run_errors = 0;
        rst_n      = 1'b0;
        start      = 1'b0;
        edge_src   = '0;
        edge_dst   = '0;
        exp_y      = '0;
        $readmemh("dv/gcn_golden.txt", golden_mem);
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (2) @(posedge clk);   // checker sees idle outputs here
        for (int c = 0; c < NUM_CASES; c++) begin
            idle = $unsigned($random(seed)) % 8;
            repeat (idle) @(posedge clk);
            #1;
            load_case(c);
            start = 1'b1;
            @(posedge clk);
            #1 start = 1'b0;
            if (c == 1) begin
                // second start while the edges are being taken
                repeat (3) @(posedge clk);
                #1 start = 1'b1;
                @(posedge clk);
                #1 start = 1'b0;
            end
            wait_for_done();
        end
        repeat (4) @(posedge clk);   // y must hold after the last run
        #1;
        if (done_count != NUM_CASES) begin
            $display("Error: saw %0d done pulses, expected %0d", done_count, NUM_CASES);
            run_errors++;
        end
        report_counts(run_errors);
        if (mismatch_count + fault_count + run_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: timeout, the runs did not finish within %0d cycles", WATCHDOG_CYCLES);
        report_counts(run_errors + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- dv/gcn_golden.txt
// per line: src ids, dst ids, feature columns 0-7, weight rows 0-7, expected classes
// hex digits run left to right from index 0 (edge slot, node or class)
// line 3 holds a zero id, a self loop, a duplicate edge and id 7, all without effect
123456 234561 300000 040000 005000 000200 000003 000000 000010 000010 100 010 001 110 011 101 200 002 121210
131512 214163 f1000a f20900 f30000 f00000 f00000 f00000 f04000 f00070 100 010 001 110 011 101 200 002 002000
031274 332146 020000 500000 006000 000000 000004 000000 000300 000040 100 010 001 110 011 101 200 002 010100
112454 233566 100002 100000 030000 000050 000000 001000 000004 000200 003 210 020 101 000 312 010 111 101220
444410 123520 ffffff ffffff ffffff ffffff ffffff ffffff ffffff ffffff f0f 0fe f0f 0fe f0f 0fe f0f 0fe 222220
123456 234565 030000 000010 010000 001000 200000 000200 000010 000003 100 010 001 110 011 101 200 002 010020

//--- build.f
common/gcn_pkg.sv
common/feat_stream_if.sv
gcn/gcn_ctrl.sv
gcn/adj_builder.sv
gcn/feat_aggregator.sv
gcn/feat_transform.sv
gcn/gcn_top.sv
dv/gcn_checker.sv
dv/gcn_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the gcn testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module gcn_tb -f build.f -o gcn_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/gcn_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
